// ==== rtl/demod_pkg.sv ====
package demod_pkg;

    // fft size
    localparam int NFFT    = 8;
    localparam int FFT_LEN = 2 ** NFFT;

    // normal cyclic prefix at this sample rate
    localparam int CP_LEN = 18;

    // 240 subcarriers of one SSB centred in the fft
    localparam int SC_START = 8;
    localparam int SC_USED  = 240;

    // SSS sits in the middle 127 subcarriers of symbol 1
    localparam int SSS_START = 64;
    localparam int SSS_LEN   = 127;

    // 20 slots of 14 symbols between SSBs
    localparam int SYMS_BTWN_SSB = 280;

    typedef logic [NFFT-1:0] sc_idx_t;  // subcarrier index
    typedef logic [8:0]      sym_idx_t; // symbol inside the SSB period
    typedef logic [4:0]      cp_cnt_t;  // prefix sample counter

endpackage

// ==== rtl/sc_stream_if.sv ====
`timescale 1ns/1ns

// one tagged frequency-domain subcarrier per valid cycle
interface sc_stream_if #(
    parameter int IN_DW = 32
);
    logic [IN_DW-1:0] data;      // {im, re}
    logic             valid;     // used subcarrier
    logic             last;      // last used subcarrier of the symbol
    logic             pbch_sym;  // symbol 0 of the period
    logic             pbch_mark;
    logic             sss_mark;

    modport src (output data, valid, last, pbch_sym, pbch_mark, sss_mark);
    modport dst (input  data, valid, last, pbch_sym, pbch_mark, sss_mark);

endinterface

// ==== rtl/cp_strip_fsm.sv ====
`timescale 1ns/1ns

module cp_strip_fsm
    import demod_pkg::*;
#(
    parameter int IN_DW      = 32,
    parameter int CP_ADVANCE = 9
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic [IN_DW-1:0] s_axis_in_tdata_i,
    input  logic             s_axis_in_tvalid_i,
    input  logic             s_axis_in_tlast_i,
    output logic [IN_DW-1:0] fft_di_o,
    output logic             fft_di_en_o
);

    typedef enum logic [1:0] {
        SKIP_CP,
        TAKE_SYMBOL,
        SKIP_END
    } cp_state_e;

    cp_state_e state;
    cp_cnt_t   cp_cnt;
    sc_idx_t   take_cnt;   // wraps at FFT_LEN by width

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= SKIP_CP;
            cp_cnt   <= '0;
            take_cnt <= '0;
        end else if (s_axis_in_tvalid_i) begin
            case (state)
                SKIP_CP: begin
                    if (cp_cnt == cp_cnt_t'(CP_ADVANCE - 1)) begin
                        state    <= TAKE_SYMBOL;
                        take_cnt <= '0;
                    end else begin
                        cp_cnt <= cp_cnt + 1'b1;
                    end
                end
                TAKE_SYMBOL: begin
                    take_cnt <= take_cnt + 1'b1;
                    if (take_cnt == sc_idx_t'(FFT_LEN - 1)) begin
                        cp_cnt <= '0;
                        // window may end exactly on tlast when CP_ADVANCE == CP_LEN
                        state  <= s_axis_in_tlast_i ? SKIP_CP : SKIP_END;
                    end
                end
                SKIP_END: begin
                    if (s_axis_in_tlast_i) state <= SKIP_CP; // drop repeated tail
                end
                default: state <= SKIP_CP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fft_di_en_o <= 1'b0;
        end else begin
            fft_di_en_o <= s_axis_in_tvalid_i && (state == TAKE_SYMBOL);
        end
    end

    always_ff @(posedge clk_i) begin
        fft_di_o <= s_axis_in_tdata_i;
    end

endmodule

// ==== rtl/symbol_counter.sv ====
`timescale 1ns/1ns

module symbol_counter
    import demod_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     fft_do_vl_i,
    output sc_idx_t  sc_idx_o,
    output sym_idx_t sym_idx_o
);

    logic sc_wrap;

    assign sc_wrap = (sc_idx_o == sc_idx_t'(FFT_LEN - 1));

    // outputs show the index of the next fft result
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sc_idx_o  <= '0;
            sym_idx_o <= '0;
        end else if (fft_do_vl_i) begin
            if (sc_wrap) begin
                sc_idx_o <= '0;
                if (sym_idx_o == sym_idx_t'(SYMS_BTWN_SSB - 1)) begin
                    sym_idx_o <= '0;
                end else begin
                    sym_idx_o <= sym_idx_o + 1'b1;
                end
            end else begin
                sc_idx_o <= sc_idx_o + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/sc_tagger.sv ====
`timescale 1ns/1ns

module sc_tagger
    import demod_pkg::*;
#(
    parameter int IN_DW = 32
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic [IN_DW-1:0] fft_do_i,
    input  logic             fft_do_vl_i,
    input  sc_idx_t          sc_idx_i,
    input  sym_idx_t         sym_idx_i,
    sc_stream_if.src         out_o
);

    logic used_sc;
    logic sss_sc;
    logic last_sc;

    assign used_sc = (sc_idx_i >= SC_START) && (sc_idx_i <= SC_START + SC_USED - 1);
    assign sss_sc  = (sc_idx_i >= SSS_START) && (sc_idx_i <= SSS_START + SSS_LEN - 1);
    assign last_sc = (sc_idx_i == SC_START + SC_USED - 1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_o.valid     <= 1'b0;
            out_o.last      <= 1'b0;
            out_o.pbch_sym  <= 1'b0;
            out_o.pbch_mark <= 1'b0;
            out_o.sss_mark  <= 1'b0;
        end else begin
            out_o.valid     <= fft_do_vl_i && used_sc;
            out_o.last      <= fft_do_vl_i && last_sc;
            out_o.pbch_sym  <= fft_do_vl_i && (sym_idx_i == 0);
            out_o.pbch_mark <= fft_do_vl_i && used_sc && (sym_idx_i == 0);
            out_o.sss_mark  <= fft_do_vl_i && sss_sc && (sym_idx_i == 1);
        end
    end

    always_ff @(posedge clk_i) begin
        out_o.data <= fft_do_i;
    end

endmodule

// ==== rtl/phase_rotator.sv ====
`timescale 1ns/1ns

module phase_rotator
    import demod_pkg::*;
#(
    parameter int IN_DW      = 32,
    parameter int CP_ADVANCE = 9
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    sc_stream_if.dst         in_i,
    output logic [IN_DW-1:0] m_axis_out_tdata_o,
    output logic             m_axis_out_tvalid_o,
    output logic             m_axis_out_tlast_o,
    output logic             m_axis_out_tuser_o,
    output logic             pbch_valid_o,
    output logic             sss_valid_o
);

    logic [4:0] in_flags;   // {valid, last, pbch_sym, pbch_mark, sss_mark}

    assign in_flags = {in_i.valid, in_i.last, in_i.pbch_sym, in_i.pbch_mark, in_i.sss_mark};

    if (CP_ADVANCE != CP_LEN) begin : g_rotate
        localparam int  HW    = IN_DW / 2;
        localparam int  D     = CP_LEN - CP_ADVANCE;
        localparam real PI    = 3.14159265358979;
        localparam real SCALE = real'(2 ** (HW - 1) - 1);

        logic [IN_DW-1:0]     coeff_rom [FFT_LEN];  // {sin, cos}
        sc_idx_t              coeff_idx;
        logic [IN_DW-1:0]     data_s1, coeff_s1;
        logic [4:0]           flags_s1, flags_s2;
        logic signed [HW-1:0] a_re, a_im, c_re, c_im;
        logic signed [2*HW-1:0] p_rr, p_ii, p_ri, p_ir;
        logic signed [2*HW:0]   sum_re, sum_im, sh_re, sh_im;

        // undo the linear phase of a window started D samples early
        initial begin
            real ang;
            for (int k = 0; k < FFT_LEN; k++) begin
                ang = 2.0 * PI * real'(k * D) / real'(FFT_LEN) + PI * real'(D);
                coeff_rom[k][HW-1:0]     = HW'($rtoi($cos(ang) * SCALE));
                coeff_rom[k][IN_DW-1:HW] = HW'($rtoi($sin(ang) * SCALE));
            end
        end

        assign a_re = data_s1[HW-1:0];
        assign a_im = data_s1[IN_DW-1:HW];
        assign c_re = coeff_s1[HW-1:0];
        assign c_im = coeff_s1[IN_DW-1:HW];

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                coeff_idx <= sc_idx_t'(SC_START);
                flags_s1  <= '0;
                flags_s2  <= '0;
            end else begin
                if (in_i.valid) begin
                    coeff_idx <= in_i.last ? sc_idx_t'(SC_START) : coeff_idx + 1'b1;
                end
                flags_s1 <= in_flags;
                flags_s2 <= flags_s1;
            end
        end

        // stage 1 reads the table and stage 2 forms the products
        always_ff @(posedge clk_i) begin
            data_s1  <= in_i.data;
            coeff_s1 <= coeff_rom[coeff_idx];
            p_rr     <= a_re * c_re;
            p_ii     <= a_im * c_im;
            p_ri     <= a_re * c_im;
            p_ir     <= a_im * c_re;
        end

        always_comb begin
            sum_re = p_rr - p_ii;
            sum_im = p_ri + p_ir;
            sh_re  = sum_re >>> (HW - 1);   // back to coefficient scale
            sh_im  = sum_im >>> (HW - 1);
        end

        always_ff @(posedge clk_i) begin
            m_axis_out_tdata_o <= {sh_im[HW-1:0], sh_re[HW-1:0]};
        end

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                m_axis_out_tvalid_o <= 1'b0;
                m_axis_out_tlast_o  <= 1'b0;
                m_axis_out_tuser_o  <= 1'b0;
                pbch_valid_o        <= 1'b0;
                sss_valid_o         <= 1'b0;
            end else begin
                m_axis_out_tvalid_o <= flags_s2[4];
                m_axis_out_tlast_o  <= flags_s2[3];
                m_axis_out_tuser_o  <= flags_s2[4] && flags_s2[2];
                pbch_valid_o        <= flags_s2[1];
                sss_valid_o         <= flags_s2[0];
            end
        end
    end else begin : g_bypass
        // no phase to correct when the window starts right after the prefix
        always_ff @(posedge clk_i) begin
            m_axis_out_tdata_o <= in_i.data;
        end

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                m_axis_out_tvalid_o <= 1'b0;
                m_axis_out_tlast_o  <= 1'b0;
                m_axis_out_tuser_o  <= 1'b0;
                pbch_valid_o        <= 1'b0;
                sss_valid_o         <= 1'b0;
            end else begin
                m_axis_out_tvalid_o <= in_flags[4];
                m_axis_out_tlast_o  <= in_flags[3];
                m_axis_out_tuser_o  <= in_flags[4] && in_flags[2];
                pbch_valid_o        <= in_flags[1];
                sss_valid_o         <= in_flags[0];
            end
        end
    end

endmodule

// ==== rtl/ofdm_demod_top.sv ====
`timescale 1ns/1ns

module ofdm_demod_top
    import demod_pkg::*;
#(
    parameter int IN_DW      = 32,
    parameter int CP_ADVANCE = 9
) (
    input  logic             clk_i,
    input  logic             reset_ni,
    // time-domain input stream
    input  logic [IN_DW-1:0] s_axis_in_tdata_i,
    input  logic             s_axis_in_tvalid_i,
    input  logic             s_axis_in_tlast_i,
    // external fft core
    output logic [IN_DW-1:0] fft_di_o,
    output logic             fft_di_en_o,
    input  logic [IN_DW-1:0] fft_do_i,
    input  logic             fft_do_vl_i,
    // corrected subcarriers
    output logic [IN_DW-1:0] m_axis_out_tdata_o,
    output logic             m_axis_out_tvalid_o,
    output logic             m_axis_out_tlast_o,
    output logic             m_axis_out_tuser_o,
    output logic             pbch_valid_o,
    output logic             sss_valid_o
);

    sc_idx_t  sc_idx;
    sym_idx_t sym_idx;

    sc_stream_if #(.IN_DW(IN_DW)) sc_if ();

    cp_strip_fsm #(
        .IN_DW      (IN_DW),
        .CP_ADVANCE (CP_ADVANCE)
    ) u_cp_strip (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_axis_in_tdata_i  (s_axis_in_tdata_i),
        .s_axis_in_tvalid_i (s_axis_in_tvalid_i),
        .s_axis_in_tlast_i  (s_axis_in_tlast_i),
        .fft_di_o           (fft_di_o),
        .fft_di_en_o        (fft_di_en_o)
    );

    symbol_counter u_sym_cnt (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .fft_do_vl_i (fft_do_vl_i),
        .sc_idx_o    (sc_idx),
        .sym_idx_o   (sym_idx)
    );

    sc_tagger #(.IN_DW(IN_DW)) u_tagger (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .fft_do_i    (fft_do_i),
        .fft_do_vl_i (fft_do_vl_i),
        .sc_idx_i    (sc_idx),
        .sym_idx_i   (sym_idx),
        .out_o       (sc_if.src)
    );

    phase_rotator #(
        .IN_DW      (IN_DW),
        .CP_ADVANCE (CP_ADVANCE)
    ) u_rotator (
        .clk_i               (clk_i),
        .reset_ni            (reset_ni),
        .in_i                (sc_if.dst),
        .m_axis_out_tdata_o  (m_axis_out_tdata_o),
        .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
        .m_axis_out_tlast_o  (m_axis_out_tlast_o),
        .m_axis_out_tuser_o  (m_axis_out_tuser_o),
        .pbch_valid_o        (pbch_valid_o),
        .sss_valid_o         (sss_valid_o)
    );

endmodule

// ==== tb/tb_ofdm_demod.sv ====
`timescale 1ns/1ns

module tb_ofdm_demod;

    localparam int  DW        = 32;
    localparam int  HW        = DW / 2;
    localparam int  FFT_N     = 256;
    localparam int  CP        = 18;
    localparam int  CP_ADV    = 9;
    localparam int  D         = CP - CP_ADV;
    localparam int  SYM_LEN   = FFT_N + CP;
    localparam int  N_SYMS    = 282;
    localparam int  PERIOD    = 280;
    localparam int  SC_N      = 240;
    localparam int  SSS_N     = 127;
    localparam int  FFT_LAT   = 20;
    localparam int  OUT_LAT   = 4;
    localparam int  DRAIN_MAX = 100;
    localparam int  RUN_NS    = N_SYMS * SYM_LEN * 2 * 10 + 20000;
    localparam real PI        = 3.14159265358979;
    localparam real SCALE     = real'(2 ** (HW - 1) - 1);
    localparam int  T_RESET = 0, T_WINDOW = 1, T_FRAME = 2, T_MARK = 3, T_PHASE = 4;

    typedef struct packed {
        logic [DW-1:0] data;
        int            due;    // cycle in which the output must show up
        int            idx;
        logic          last;
        logic          pbch;
        logic          sss;
    } sc_exp_t;

    logic          clk;
    logic          reset_ni;
    logic [DW-1:0] in_data;
    logic          in_valid;
    logic          in_last;
    logic [DW-1:0] fft_di;
    logic          fft_di_en;
    logic [DW-1:0] fft_do = '0;
    logic          fft_do_vl = 1'b0;
    logic [DW-1:0] m_tdata;
    logic          m_tvalid, m_tlast, m_tuser, pbch_valid, sss_valid;

    logic [DW-1:0] dly_data [FFT_LAT] = '{default: '0};
    logic          dly_vl   [FFT_LAT] = '{default: 1'b0};
    logic [DW-1:0] win_q [$];
    sc_exp_t       exp_q [$];
    logic [31:0]   rng;
    int            cyc = 0;
    int            fft_cnt = 0, win_cnt = 0, out_cnt = 0, sym_out_cnt = 0;
    int            pbch_cnt = 0, sss_cnt = 0;
    int            chk_cnt [5] = '{default: 0};
    int            err_cnt [5] = '{default: 0};
    string         test_name [5] = '{"reset", "window", "framing", "marking", "phase"};

    ofdm_demod_top uut (
        .clk_i (clk), .reset_ni (reset_ni),
        .s_axis_in_tdata_i (in_data), .s_axis_in_tvalid_i (in_valid),
        .s_axis_in_tlast_i (in_last),
        .fft_di_o (fft_di), .fft_di_en_o (fft_di_en),
        .fft_do_i (fft_do), .fft_do_vl_i (fft_do_vl),
        .m_axis_out_tdata_o (m_tdata), .m_axis_out_tvalid_o (m_tvalid),
        .m_axis_out_tlast_o (m_tlast), .m_axis_out_tuser_o (m_tuser),
        .pbch_valid_o (pbch_valid), .sss_valid_o (sss_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // reference rotation by the window-advance coefficient of subcarrier k
    function automatic logic [DW-1:0] rotate(input logic [DW-1:0] x, input int k);
        real    ang;
        longint c_re, c_im, a_re, a_im, y_re, y_im;
        ang  = 2.0 * PI * real'(k * D) / real'(FFT_N) + PI * real'(D);
        c_re = longint'($rtoi($cos(ang) * SCALE));
        c_im = longint'($rtoi($sin(ang) * SCALE));
        a_re = longint'($signed(x[HW-1:0]));
        a_im = longint'($signed(x[DW-1:HW]));
        y_re = (a_re * c_re - a_im * c_im) >>> (HW - 1);
        y_im = (a_re * c_im + a_im * c_re) >>> (HW - 1);
        return {y_im[HW-1:0], y_re[HW-1:0]};
    endfunction

    task automatic check_value(input int t, input logic [31:0] exp_v, input logic [31:0] act_v);
        chk_cnt[t]++;
        assert (exp_v === act_v) else begin
            err_cnt[t]++;
            $display("FAILED %s: expected %h, actual %h", test_name[t], exp_v, act_v);
        end
    endtask

    task automatic check_true(input int t, input logic cond, input string what);
        chk_cnt[t]++;
        assert (cond) else begin
            err_cnt[t]++;
            $display("%s check: %s", test_name[t], what);
        end
    endtask

    // one valid sample after random gaps of about one cycle in eight
    task automatic send_sample(input logic [DW-1:0] d, input logic l);
        rng = lcg(rng);
        while (rng[30:28] == 3'd0) begin
            in_valid = 1'b0;
            in_last  = 1'b0;
            @(negedge clk);
            rng = lcg(rng);
        end
        in_data  = d;
        in_valid = 1'b1;
        in_last  = l;
        @(negedge clk);
    endtask

    // identity fft model with a fixed latency
    always @(negedge clk) begin
        int idx;
        int sym;
        idx = fft_cnt % FFT_N;
        sym = (fft_cnt / FFT_N) % PERIOD;
        if (dly_vl[FFT_LAT-1]) begin
            if (idx >= 8 && idx <= 247) begin
                exp_q.push_back('{data: dly_data[FFT_LAT-1], due: cyc + OUT_LAT, idx: idx,
                                  last: idx == 247, pbch: sym == 0,
                                  sss: sym == 1 && idx >= 64 && idx <= 190});
            end
            fft_cnt++;
        end
        fft_do    = dly_data[FFT_LAT-1];
        fft_do_vl = dly_vl[FFT_LAT-1];
        for (int i = FFT_LAT - 1; i > 0; i--) begin
            dly_data[i] = dly_data[i-1];
            dly_vl[i]   = dly_vl[i-1];
        end
        dly_data[0] = fft_di;
        dly_vl[0]   = fft_di_en && reset_ni;
    end

    always @(negedge clk) begin
        if (reset_ni && fft_di_en) begin
            win_cnt++;
            if (win_q.size() == 0) begin
                check_true(T_WINDOW, 1'b0, "sample sent to the FFT outside a window");
            end else begin
                check_value(T_WINDOW, win_q.pop_front(), fft_di);
            end
        end
    end

    always @(negedge clk) begin
        sc_exp_t e;
        if (reset_ni && m_tvalid) begin
            out_cnt++;
            sym_out_cnt++;
            pbch_cnt += pbch_valid;
            sss_cnt  += sss_valid;
            if (exp_q.size() == 0) begin
                check_true(T_FRAME, 1'b0, "output valid with no subcarrier pending");
            end else begin
                e = exp_q.pop_front();
                check_value(T_FRAME, e.due, cyc);
                check_value(T_FRAME, e.last, m_tlast);
                check_value(T_MARK, {e.pbch, e.pbch}, {m_tuser, pbch_valid});
                check_value(T_MARK, e.sss, sss_valid);
                check_value(T_PHASE, rotate(e.data, e.idx), m_tdata);
            end
            if (m_tlast) begin
                check_value(T_FRAME, SC_N, sym_out_cnt);
                sym_out_cnt = 0;
            end
        end else if (reset_ni) begin
            check_value(T_FRAME, 0, m_tlast);
            check_value(T_MARK, 0, {m_tuser, pbch_valid, sss_valid});
            if (exp_q.size() > 0 && exp_q[0].due <= cyc) begin
                check_true(T_FRAME, 1'b0, "expected subcarrier did not appear in time");
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        #(RUN_NS);
        $display("watchdog expired before the run completed");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [DW-1:0] sample;
        int            errors;
        int            checks;
        rng      = 32'd11;
        reset_ni = 1'b0;
        in_data  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value(T_RESET, 0, {fft_di_en, m_tvalid, pbch_valid, sss_valid});
        end
        reset_ni = 1'b1;
        @(negedge clk);
        check_value(T_RESET, 0, {fft_di_en, m_tvalid, pbch_valid, sss_valid});

        for (int s = 0; s < N_SYMS; s++) begin
            for (int p = 0; p < SYM_LEN; p++) begin
                rng    = lcg(rng);
                sample = rng;
                if (p >= CP_ADV && p < CP_ADV + FFT_N) win_q.push_back(sample);
                send_sample(sample, p == SYM_LEN - 1);
            end
            check_value(T_WINDOW, (s + 1) * FFT_N, win_cnt);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;

        // let the fft model and the pipeline drain
        for (int w = 0; w < DRAIN_MAX && (out_cnt < N_SYMS * SC_N || exp_q.size() != 0); w++) begin
            @(negedge clk);
        end
        check_value(T_FRAME, N_SYMS * SC_N, out_cnt);
        check_value(T_WINDOW, 0, win_q.size());
        check_value(T_MARK, 2 * SC_N, pbch_cnt);
        check_value(T_MARK, 2 * SSS_N, sss_cnt);

        errors = 0;
        checks = 0;
        for (int t = 0; t < 5; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name[t], chk_cnt[t], err_cnt[t]);
            errors += err_cnt[t];
            checks += chk_cnt[t];
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/demod_pkg.sv
rtl/sc_stream_if.sv
rtl/cp_strip_fsm.sv
rtl/symbol_counter.sv
rtl/sc_tagger.sv
rtl/phase_rotator.sv
rtl/ofdm_demod_top.sv
tb/tb_ofdm_demod.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the OFDM demodulator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_ofdm_demod -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1
